// File: decimal_print_unit.f
+incdir+include
source/print_pkg.sv
source/print_request_decoder.sv
source/binary_to_bcd.sv
source/bcd_digit_formatter.sv
source/decimal_char_streamer.sv
source/decimal_print_unit.sv
dv/tb_decimal_print_unit.sv

// File: run_sim.sh
#!/bin/sh
# build the decimal print unit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_decimal_print_unit \
  -f decimal_print_unit.f --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_decimal_print_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "$output" | grep -qx "TESTBENCH PASSED" || exit 1
exit 0

// File: dv/tb_decimal_print_unit.sv
`timescale 1ns/1ns

`include "print_defs.svh"

module tb_decimal_print_unit;

  localparam int REQUESTS     = 200;
  localparam int DONE_TIMEOUT = 1000;  // cycles per wait

  logic        clk_i;
  logic        rst_i;
  logic        ce_i;
  logic        start_i;
  logic        signed_i;
  logic [31:0] value_i;
  logic [7:0]  char_o;
  logic        char_valid_o;
  logic        char_last_o;
  logic        done_o;

  int seed            = 32'h2c0e40e4;
  int value_errors    = 0;
  int protocol_errors = 0;
  int monitor_errors  = 0;
  int timeouts        = 0;
  bit timed_out       = 1'b0;
  bit hold_ce_low     = 1'b0;  // freezes the unit
  bit junk_starts     = 1'b0;  // extra starts while busy

  logic [7:0] expected[$];
  logic [7:0] got_chars[$];   // every character seen since reset
  time        got_times[$];
  int         last_marks[$];  // character count at each char_last_o

  decimal_print_unit i_decimal_print_unit (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ce_i         (ce_i),
    .start_i      (start_i),
    .signed_i     (signed_i),
    .value_i      (value_i),
    .char_o       (char_o),
    .char_valid_o (char_valid_o),
    .char_last_o  (char_last_o),
    .done_o       (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ---------------------------------------------------------------------
  // output monitor, inputs settle after the falling edge
  // ---------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_i) begin
      assert (ce_i || !char_valid_o) else begin
        monitor_errors++;
        $display("char_valid_o went high at %0t while ce_i was low", $time);
      end
      assert (char_valid_o || !char_last_o) else begin
        monitor_errors++;
        $display("char_last_o went high at %0t without char_valid_o", $time);
      end
      if (char_valid_o) begin
        got_chars.push_back(char_o);
        got_times.push_back($time);
        if (char_last_o) last_marks.push_back(got_chars.size());
      end
    end
  end

  // decimal text by repeated division
  function automatic void build_expected(input logic [31:0] value, input logic is_signed);
    longint number;
    bit     negative;
    number   = is_signed ? longint'($signed(value)) : longint'(value);
    negative = number < 0;
    if (negative) number = -number;
    expected.delete();
    for (int n = 0; n == 0 || number != 0; n++) begin
      expected.push_front(8'(`PRINT_ASCII_ZERO + number % 10));
      number = number / 10;
    end
    if (negative) expected.push_front(`PRINT_ASCII_MINUS);
  endfunction

  task automatic next_cycle();
    @(negedge clk_i);
    ce_i    = hold_ce_low ? 1'b0 : (({$random(seed)} % 4) != 0);  // low about 25%
    start_i = 1'b0;
    if (junk_starts && !done_o && ({$random(seed)} % 6) == 0) begin
      start_i  = 1'b1;  // must be dropped
      signed_i = 1'($random(seed));
      value_i  = $random(seed);
    end
  endtask

  task automatic check_text(input logic [31:0] value, input int first, input int marks);
    assert (got_chars.size() - first == expected.size()) else begin
      value_errors++;
      $display("error at %0t: char_valid_o count = %0d, expected %0d (value %h)",
               $time, got_chars.size() - first, expected.size(), value);
    end
    for (int k = 0; k < expected.size() && first + k < got_chars.size(); k++) begin
      assert (got_chars[first + k] == expected[k]) else begin
        value_errors++;
        $display("error at %0t: char_o = 0x%02h '%c', expected 0x%02h '%c'", got_times[first + k],
                 got_chars[first + k], got_chars[first + k], expected[k], expected[k]);
      end
    end
    assert (last_marks.size() - marks == 1 && last_marks[marks] == first + expected.size())
    else begin
      protocol_errors++;
      $display("char_last_o was not high on exactly the final character of value %h", value);
    end
  endtask

  task automatic run_request(input logic [31:0] value, input logic is_signed, input int frozen);
    int cycles;
    int first;
    int marks;
    if (timed_out) return;
    cycles = 0;
    while (!done_o && cycles < DONE_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    assert (done_o) else begin
      timeouts++;
      timed_out = 1'b1;
      $display("timeout: done_o stayed low before a new request could start");
    end
    if (timed_out) return;
    build_expected(value, is_signed);
    first    = got_chars.size();
    marks    = last_marks.size();
    start_i  = 1'b1;
    signed_i = is_signed;
    value_i  = value;
    if (frozen > 0) begin
      hold_ce_low = 1'b1;
      ce_i        = 1'b0;
      for (int k = 0; k < frozen; k++) next_cycle();
      assert (got_chars.size() == first && !done_o) else begin
        protocol_errors++;
        $display("request finished or printed characters while ce_i was held low");
      end
      hold_ce_low = 1'b0;
    end
    next_cycle();
    cycles = 1;
    while (!done_o && cycles < DONE_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    assert (done_o) else begin
      timeouts++;
      timed_out = 1'b1;
      $display("timeout: request for value %h never finished", value);
    end
    if (!timed_out) check_text(value, first, marks);
  endtask

  // ---------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------
  initial begin
    logic [31:0] value;
    logic        is_signed;
    int          pick;
    rst_i    = 1'b1;
    ce_i     = 1'b0;
    start_i  = 1'b0;
    signed_i = 1'b0;
    value_i  = '0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;

    assert (done_o) else begin
      protocol_errors++;
      $display("done_o was low right after reset");
    end
    for (int k = 0; k < 8; k++) next_cycle();
    assert (got_chars.size() == 0) else begin
      protocol_errors++;
      $display("characters appeared before any request was made");
    end

    run_request(32'd90210, 1'b0, 80);  // frozen by ce_i first
    run_request(32'hffffffff, 1'b1, 40);
    run_request(32'd0, 1'b0, 0);
    run_request(32'd0, 1'b1, 0);
    run_request(32'hffffffff, 1'b0, 0);
    run_request(32'h80000000, 1'b1, 0);
    run_request(32'h80000000, 1'b0, 0);
    run_request(32'h7fffffff, 1'b1, 0);
    run_request(32'd10, 1'b1, 0);

    junk_starts = 1'b1;
    for (int n = 0; n < REQUESTS; n++) begin
      pick      = {$random(seed)} % 8;
      value     = $random(seed);
      is_signed = ({$random(seed)} % 2) == 1;
      case (pick)
        0: value = value % 32'd10;
        1: value = value % 32'd100000;
        2: value = value[0] ? 32'h80000000 : 32'hffffffff;
        3: value = value[0] ? 32'd0 : 32'd999999999;
        default: ;
      endcase
      run_request(value, is_signed, 0);
    end

    $display("errors: %0d value, %0d protocol, %0d monitor, %0d timeout",
             value_errors, protocol_errors, monitor_errors, timeouts);
    if (value_errors + protocol_errors + monitor_errors + timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: source/decimal_print_unit.sv
`timescale 1ns/1ns

module decimal_print_unit
  import print_pkg::*;
#(
  parameter int VALUE_BITS     = 32,
  parameter int BCD_DIGITS     = 10,
  parameter int BIT_COUNT_BITS = 5
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  ce_i,
  input  logic                  start_i,
  input  logic                  signed_i,
  input  logic [VALUE_BITS-1:0] value_i,
  output char_t                 char_o,
  output logic                  char_valid_o,
  output logic                  char_last_o,
  output logic                  done_o
);

  logic                    conv_start;
  logic [VALUE_BITS-1:0]   magnitude;
  logic                    negative;
  digit_t [BCD_DIGITS-1:0] bcd;
  logic                    conv_done;
  logic                    conv_finish;
  char_t  [BCD_DIGITS-1:0] digit_chars;
  width_t                  sig_digits;
  logic                    stream_idle;

  // decoder idle means no start pulse in flight
  assign done_o = ~conv_start & conv_done & stream_idle;

  print_request_decoder #(
    .VALUE_BITS (VALUE_BITS)
  ) i_print_request_decoder (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .start_i      (start_i),
    .idle_i       (done_o),
    .signed_i     (signed_i),
    .value_i      (value_i),
    .conv_start_o (conv_start),
    .magnitude_o  (magnitude),
    .negative_o   (negative)
  );

  binary_to_bcd #(
    .VALUE_BITS     (VALUE_BITS),
    .BCD_DIGITS     (BCD_DIGITS),
    .BIT_COUNT_BITS (BIT_COUNT_BITS)
  ) i_binary_to_bcd (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ce_i         (ce_i),
    .start_i      (conv_start),
    .dat_binary_i (magnitude),
    .dat_bcd_o    (bcd),
    .done_o       (conv_done),
    .finish_o     (conv_finish)
  );

  bcd_digit_formatter #(
    .BCD_DIGITS (BCD_DIGITS)
  ) i_bcd_digit_formatter (
    .bcd_i        (bcd),
    .chars_o      (digit_chars),
    .sig_digits_o (sig_digits)
  );

  decimal_char_streamer #(
    .BCD_DIGITS (BCD_DIGITS)
  ) i_decimal_char_streamer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ce_i         (ce_i),
    .load_i       (conv_finish),
    .negative_i   (negative),
    .chars_i      (digit_chars),
    .sig_digits_i (sig_digits),
    .char_o       (char_o),
    .char_valid_o (char_valid_o),
    .char_last_o  (char_last_o),
    .idle_o       (stream_idle)
  );

endmodule

// File: source/decimal_char_streamer.sv
`timescale 1ns/1ns

module decimal_char_streamer
  import print_pkg::*;
#(
  parameter int BCD_DIGITS = 10
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   ce_i,
  input  logic                   load_i,
  input  logic                   negative_i,
  input  char_t [BCD_DIGITS-1:0] chars_i,
  input  width_t                 sig_digits_i,
  output char_t                  char_o,
  output logic                   char_valid_o,
  output logic                   char_last_o,
  output logic                   idle_o
);

  stream_state_t         state;
  width_t                idx;      // digit being sent, counts down
  char_t [BCD_DIGITS-1:0] chars_q;

  // ----------------------------------------------------------------------
  // state machine
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= IDLE;
      idx   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (load_i) begin
            idx   <= sig_digits_i - 1'b1;
            state <= negative_i ? SIGN : DIGITS;
          end
        end
        SIGN: begin
          if (ce_i) begin
            state <= DIGITS;
          end
        end
        DIGITS: begin
          if (ce_i) begin
            if (idx == '0) begin
              state <= IDLE;  // final character sent
            end else begin
              idx <= idx - 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // character snapshot
  always_ff @(posedge clk_i) begin
    if (load_i && state == IDLE) begin
      chars_q <= chars_i;
    end
  end

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------
  assign char_valid_o = (state != IDLE) && ce_i;
  assign char_last_o  = char_valid_o && (state == DIGITS) && (idx == '0);
  assign char_o       = (state == SIGN) ? ASCII_MINUS : chars_q[idx];

  // busy already on the load cycle
  assign idle_o = (state == IDLE) && !load_i;

endmodule

// File: source/bcd_digit_formatter.sv
`timescale 1ns/1ns

module bcd_digit_formatter
  import print_pkg::*;
#(
  parameter int BCD_DIGITS = 10
) (
  input  digit_t [BCD_DIGITS-1:0] bcd_i,
  output char_t  [BCD_DIGITS-1:0] chars_o,
  output width_t                  sig_digits_o
);

  // ----------------------------------------------------------------------
  // digit to ascii
  // ----------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < BCD_DIGITS; i++) begin
      if (bcd_i[i] > 4'd9) begin
        chars_o[i] = ASCII_ZERO;  // not a decimal code
      end else begin
        chars_o[i] = ASCII_ZERO + char_t'(bcd_i[i]);
      end
    end
  end

  // ----------------------------------------------------------------------
  // significant digits
  // ----------------------------------------------------------------------
  // upward scan, so the highest non-zero digit sets the count last
  always_comb begin
    sig_digits_o = width_t'(1);  // zero still prints one digit
    for (int i = 0; i < BCD_DIGITS; i++) begin
      if (bcd_i[i] != '0) begin
        sig_digits_o = width_t'(i + 1);
      end
    end
  end

endmodule

// File: source/binary_to_bcd.sv
`timescale 1ns/1ns

module binary_to_bcd
  import print_pkg::*;
#(
  parameter int VALUE_BITS     = 32,
  parameter int BCD_DIGITS     = 10,
  parameter int BIT_COUNT_BITS = 5
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   ce_i,
  input  logic                   start_i,
  input  logic [VALUE_BITS-1:0]  dat_binary_i,
  output digit_t [BCD_DIGITS-1:0] dat_bcd_o,
  output logic                   done_o,
  output logic                   finish_o
);

  logic [VALUE_BITS-1:0]     bin_reg;
  logic [VALUE_BITS-1:0]     bin_next;
  logic [4*BCD_DIGITS-1:0]   bcd_reg;
  logic [4*BCD_DIGITS-1:0]   bcd_next;
  logic                      busy;
  logic [BIT_COUNT_BITS-1:0] bit_count;
  logic                      bit_count_done;

  // ----------------------------------------------------------------------
  // add-3 adjust on every digit above four, then shift in one bit
  // ----------------------------------------------------------------------
  function automatic logic [4*BCD_DIGITS-1:0] bcd_shift(
    input logic [4*BCD_DIGITS-1:0] din,
    input logic                    new_bit
  );
    logic [4*BCD_DIGITS-1:0] adjusted;
    digit_t                  digit;
    adjusted = din;
    for (int k = 0; k < BCD_DIGITS; k++) begin
      digit = din[4*k +: 4];
      if (digit > 4'd4) begin
        adjusted[4*k +: 4] = digit + 4'd3;
      end
    end
    return {adjusted[4*BCD_DIGITS-2:0], new_bit};
  endfunction

  assign bin_next       = {bin_reg[VALUE_BITS-2:0], 1'b0};
  assign bcd_next       = bcd_shift(bcd_reg, bin_reg[VALUE_BITS-1]);
  assign bit_count_done = (bit_count == BIT_COUNT_BITS'(VALUE_BITS - 1));

  // ----------------------------------------------------------------------
  // busy flag, bit counter and finish pulse
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy      <= 1'b0;
      bit_count <= '0;
      finish_o  <= 1'b0;
    end else begin
      finish_o <= 1'b0;
      if (start_i && !busy) begin
        busy      <= 1'b1;
        bit_count <= '0;
      end else if (busy && ce_i) begin
        if (bit_count_done) begin
          busy     <= 1'b0;  // last shift, result written below
          finish_o <= 1'b1;
        end else begin
          bit_count <= bit_count + 1'b1;
        end
      end
    end
  end

  // shift registers and result
  always_ff @(posedge clk_i) begin
    if (start_i && !busy) begin
      bin_reg <= dat_binary_i;
      bcd_reg <= '0;
    end else if (busy && ce_i) begin
      if (bit_count_done) begin
        dat_bcd_o <= bcd_next;
      end else begin
        bin_reg <= bin_next;
        bcd_reg <= bcd_next;
      end
    end
  end

  assign done_o = ~busy;

endmodule

// File: source/print_request_decoder.sv
`timescale 1ns/1ns

module print_request_decoder #(
  parameter int VALUE_BITS = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  start_i,
  input  logic                  idle_i,
  input  logic                  signed_i,
  input  logic [VALUE_BITS-1:0] value_i,
  output logic                  conv_start_o,
  output logic [VALUE_BITS-1:0] magnitude_o,
  output logic                  negative_o
);

  logic accept;
  logic is_negative;

  assign accept      = start_i & idle_i;  // starts while busy are dropped
  assign is_negative = signed_i & value_i[VALUE_BITS-1];

  // control flags
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      conv_start_o <= 1'b0;
      negative_o   <= 1'b0;
    end else begin
      conv_start_o <= accept;
      if (accept) begin
        negative_o <= is_negative;  // held until the next request
      end
    end
  end

  // the most negative value negates back to itself, which is the right
  // unsigned magnitude at this width
  always_ff @(posedge clk_i) begin
    if (accept) begin
      magnitude_o <= is_negative ? -value_i : value_i;
    end
  end

endmodule

// File: source/print_pkg.sv
`include "print_defs.svh"

package print_pkg;

  typedef logic [7:0] char_t;   // one ascii character
  typedef logic [3:0] digit_t;  // one bcd digit
  typedef logic [3:0] width_t;  // significant digit count, 1..10

  // character streamer states
  typedef enum logic [1:0] {
    IDLE,
    SIGN,
    DIGITS
  } stream_state_t;

  localparam char_t ASCII_ZERO  = `PRINT_ASCII_ZERO;
  localparam char_t ASCII_MINUS = `PRINT_ASCII_MINUS;

endpackage

// File: include/print_defs.svh
`ifndef PRINT_DEFS_SVH
`define PRINT_DEFS_SVH

// ascii codes used by the print unit and the testbench model
`define PRINT_ASCII_ZERO  8'h30
`define PRINT_ASCII_MINUS 8'h2d

`endif
